//--- include/eeprom_config.svh
`ifndef EEPROM_CONFIG_SVH
`define EEPROM_CONFIG_SVH

// array size, 24C16 style part
`define EEPROM_DEPTH 2048

`define EEPROM_ADDR_W 11

// upper nibble of every control byte
`define EEPROM_DEV_TYPE 4'b1010

// bytes in flight from decoder to engine
`define EEPROM_LINK_CREDITS 2

`define EEPROM_CREDIT_W 2

`endif

//--- hw/eeprom_pkg.sv
package eeprom_pkg;

    // bus decoder
    typedef enum logic [2:0] {
        IDLE,
        RX_BITS,
        RX_ACK,
        TX_BYTE,
        TX_ACK,
        IGNORE
    } dec_state_e;

    // tag on every byte sent to the engine
    typedef enum logic [1:0] {
        KIND_FIRST,
        KIND_NEXT,
        // no data, marks stop or abort
        KIND_STOP
    } byte_kind_e;

    // command engine
    typedef enum logic [1:0] {
        CMD_IDLE,
        CMD_ADDR,
        CMD_WRITE,
        CMD_READ
    } cmd_state_e;

endpackage

//--- hw/eeprom_links.sv
`timescale 1ns/100ps

// received bytes, decoder to engine, credit based
interface byte_link_if;
    logic       valid;
    logic [7:0] data;
    // byte_kind_e code
    logic [1:0] kind;
    logic       credit;
    logic       ack_ok;
    logic       read_mode;

    modport decoder (
        output valid, data, kind,
        input  credit, ack_ok, read_mode
    );

    modport engine (
        input  valid, data, kind,
        output credit, ack_ok, read_mode
    );
endinterface

// read path between engine, shifter and decoder
interface tx_link_if;
    logic       load;
    logic [7:0] rd_data;
    logic       fall_tick;
    logic       rise_tick;
    logic       tx_active;
    // synchronized data line for the ack sample
    logic       line_bit;
    logic       drive_low;
    logic       next_req;
    logic       done;

    modport engine (
        output load, rd_data,
        input  next_req, done
    );

    modport decoder (
        output fall_tick, rise_tick, tx_active, line_bit,
        input  drive_low, next_req, done
    );

    modport shifter (
        input  load, rd_data, fall_tick, rise_tick, tx_active, line_bit,
        output drive_low, next_req, done
    );
endinterface

//--- hw/bus_decoder.sv
`timescale 1ns/100ps
`include "eeprom_config.svh"

module bus_decoder (
    input  logic        scl,
    input  logic        reset,
    input  logic        bus_clk,
    input  logic        bus_data_in,
    byte_link_if.decoder link,
    tx_link_if.decoder   tx,
    output logic        ack_low
);

    logic [1:0] clk_sync;
    logic [1:0] dat_sync;
    logic       clk_q;
    logic       line_q;
    logic       line;
    logic       start_cond;
    logic       stop_cond;
    eeprom_pkg::dec_state_e state;
    logic [3:0] bit_cnt;
    logic [7:0] shift_reg;
    logic       first_byte;
    logic       ack_pend;
    logic       read_pend;
    logic [`EEPROM_CREDIT_W-1:0] credits;

    // wired-and view of the line, our own drive pulls it low
    assign line = dat_sync[1] & ~(ack_low | tx.drive_low);

    assign tx.rise_tick = clk_sync[1] & ~clk_q;
    assign tx.fall_tick = ~clk_sync[1] & clk_q;
    assign tx.line_bit  = line;

    assign start_cond = clk_sync[1] & clk_q & line_q & ~line;
    assign stop_cond  = clk_sync[1] & clk_q & ~line_q & line;

    assign link.data = shift_reg;

    always_ff @(posedge scl)
    begin
        if (reset)
        begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_q    <= 1'b1;
            line_q   <= 1'b1;
        end
        else
        begin
            clk_sync <= {clk_sync[0], bus_clk};
            dat_sync <= {dat_sync[0], bus_data_in};
            clk_q    <= clk_sync[1];
            line_q   <= line;
        end
    end

    always_ff @(posedge scl)
    begin
        if (reset)
            credits <= `EEPROM_CREDIT_W'(`EEPROM_LINK_CREDITS);
        else if (link.valid && !link.credit)
            credits <= credits - 1'b1;
        else if (!link.valid && link.credit)
            credits <= credits + 1'b1;
    end

    // msb arrives first
    always_ff @(posedge scl)
    begin
        if (state == eeprom_pkg::RX_BITS && tx.rise_tick)
            shift_reg <= {shift_reg[6:0], line};
    end

    always_ff @(posedge scl)
    begin
        if (reset)
        begin
            state        <= eeprom_pkg::IDLE;
            bit_cnt      <= '0;
            first_byte   <= 1'b0;
            ack_pend     <= 1'b0;
            read_pend    <= 1'b0;
            ack_low      <= 1'b0;
            link.valid   <= 1'b0;
            link.kind    <= eeprom_pkg::KIND_STOP;
            tx.tx_active <= 1'b0;
        end
        else
        begin
            link.valid <= 1'b0;
            if (link.credit)
            begin
                ack_pend  <= link.ack_ok;
                read_pend <= link.read_mode;
            end
            if (start_cond || stop_cond)
            begin
                // tell the engine to drop whatever it was doing
                if (state != eeprom_pkg::IDLE && credits != '0)
                begin
                    link.valid <= 1'b1;
                    link.kind  <= eeprom_pkg::KIND_STOP;
                end
                ack_low      <= 1'b0;
                tx.tx_active <= 1'b0;
                bit_cnt      <= '0;
                first_byte   <= 1'b1;
                if (start_cond)
                    state <= eeprom_pkg::RX_BITS;
                else
                    state <= eeprom_pkg::IDLE;
            end
            else
            begin
                case (state)
                    eeprom_pkg::RX_BITS:
                    begin
                        if (tx.rise_tick)
                        begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == 4'd7)
                            begin
                                if (credits != '0)
                                begin
                                    link.valid <= 1'b1;
                                    link.kind  <= first_byte ? eeprom_pkg::KIND_FIRST
                                                             : eeprom_pkg::KIND_NEXT;
                                    ack_pend   <= 1'b0;
                                    read_pend  <= 1'b0;
                                    state      <= eeprom_pkg::RX_ACK;
                                end
                                else
                                    state <= eeprom_pkg::IGNORE;
                            end
                        end
                    end
                    eeprom_pkg::RX_ACK:
                    begin
                        // first fall starts the ack slot, second one ends it
                        if (tx.fall_tick)
                        begin
                            if (ack_low)
                            begin
                                ack_low    <= 1'b0;
                                bit_cnt    <= '0;
                                first_byte <= 1'b0;
                                if (read_pend)
                                    state <= eeprom_pkg::TX_BYTE;
                                else
                                    state <= eeprom_pkg::RX_BITS;
                            end
                            else if (ack_pend)
                            begin
                                ack_low      <= 1'b1;
                                tx.tx_active <= read_pend;
                            end
                            else
                                state <= eeprom_pkg::IGNORE;
                        end
                    end
                    eeprom_pkg::TX_BYTE:
                    begin
                        if (tx.rise_tick)
                        begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == 4'd7)
                                state <= eeprom_pkg::TX_ACK;
                        end
                    end
                    eeprom_pkg::TX_ACK:
                    begin
                        if (tx.next_req)
                        begin
                            bit_cnt <= '0;
                            state   <= eeprom_pkg::TX_BYTE;
                        end
                        else if (tx.done)
                        begin
                            tx.tx_active <= 1'b0;
                            state        <= eeprom_pkg::IGNORE;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- hw/command_engine.sv
`timescale 1ns/100ps
`include "eeprom_config.svh"

module command_engine (
    input logic         scl,
    input logic         reset,
    byte_link_if.engine link,
    tx_link_if.engine   tx
);

    logic [7:0] mem [0:`EEPROM_DEPTH-1];
    logic [`EEPROM_ADDR_W-1:0] addr;
    eeprom_pkg::cmd_state_e state;
    logic is_control;
    logic mem_we;
    logic fetch;

    assign is_control = (link.data[7:4] == `EEPROM_DEV_TYPE);

    assign mem_we = link.valid && (link.kind == eeprom_pkg::KIND_NEXT)
                    && (state == eeprom_pkg::CMD_WRITE);

    // first fetch follows the read credit, later ones the master's ack
    assign fetch = (link.credit && link.read_mode) || tx.next_req;

    always_ff @(posedge scl)
    begin
        if (mem_we)
            mem[addr] <= link.data;
        if (fetch)
            tx.rd_data <= mem[addr];
    end

    always_ff @(posedge scl)
    begin
        if (reset)
        begin
            state          <= eeprom_pkg::CMD_IDLE;
            addr           <= '0;
            link.credit    <= 1'b0;
            link.ack_ok    <= 1'b0;
            link.read_mode <= 1'b0;
            tx.load        <= 1'b0;
        end
        else
        begin
            // every byte is answered on the next cycle
            link.credit <= link.valid;
            tx.load     <= fetch;
            if (link.valid)
            begin
                case (link.kind)
                    eeprom_pkg::KIND_FIRST:
                    begin
                        link.read_mode <= 1'b0;
                        link.ack_ok    <= is_control;
                        if (is_control)
                        begin
                            // page bits select the 256 byte block
                            addr[`EEPROM_ADDR_W-1:8] <= link.data[3:1];
                            if (link.data[0])
                            begin
                                link.read_mode <= 1'b1;
                                state          <= eeprom_pkg::CMD_READ;
                            end
                            else
                                state <= eeprom_pkg::CMD_ADDR;
                        end
                        else
                            state <= eeprom_pkg::CMD_IDLE;
                    end
                    eeprom_pkg::KIND_NEXT:
                    begin
                        link.read_mode <= 1'b0;
                        link.ack_ok    <= (state == eeprom_pkg::CMD_ADDR)
                                          || (state == eeprom_pkg::CMD_WRITE);
                        if (state == eeprom_pkg::CMD_ADDR)
                        begin
                            addr[7:0] <= link.data;
                            state     <= eeprom_pkg::CMD_WRITE;
                        end
                        else if (state == eeprom_pkg::CMD_WRITE)
                            addr <= addr + 1'b1;
                    end
                    default:
                    begin
                        link.ack_ok    <= 1'b0;
                        link.read_mode <= 1'b0;
                        state          <= eeprom_pkg::CMD_IDLE;
                    end
                endcase
            end
            else if (fetch)
                addr <= addr + 1'b1;
            else if (tx.done)
                state <= eeprom_pkg::CMD_IDLE;
        end
    end

endmodule

//--- hw/read_shifter.sv
`timescale 1ns/100ps

module read_shifter (
    input  logic        scl,
    input  logic        reset,
    tx_link_if.shifter  tx,
    output logic        tx_low
);

    logic [7:0] shift_reg;
    logic [3:0] bit_cnt;
    logic       armed;
    logic       shift_en;

    // line let go as soon as the decoder takes the bus back
    assign tx_low = tx.drive_low && tx.tx_active;

    assign shift_en = tx.tx_active && armed && tx.fall_tick && (bit_cnt < 4'd8);

    always_ff @(posedge scl)
    begin
        if (tx.load)
            shift_reg <= tx.rd_data;
        else if (shift_en)
            shift_reg <= {shift_reg[6:0], 1'b0};
    end

    always_ff @(posedge scl)
    begin
        if (reset)
        begin
            tx.drive_low <= 1'b0;
            tx.next_req  <= 1'b0;
            tx.done      <= 1'b0;
            bit_cnt      <= '0;
            armed        <= 1'b0;
        end
        else
        begin
            tx.next_req <= 1'b0;
            tx.done     <= 1'b0;
            if (tx.load)
            begin
                armed   <= 1'b1;
                bit_cnt <= '0;
            end
            else if (!tx.tx_active)
                tx.drive_low <= 1'b0;
            else if (armed && tx.fall_tick)
            begin
                if (bit_cnt < 4'd8)
                begin
                    // open drain, a one leaves the line released
                    tx.drive_low <= ~shift_reg[7];
                    bit_cnt      <= bit_cnt + 1'b1;
                end
                else if (bit_cnt == 4'd8)
                begin
                    tx.drive_low <= 1'b0;
                    bit_cnt      <= 4'd9;
                end
            end
            else if (armed && tx.rise_tick && bit_cnt == 4'd9)
            begin
                // master ack slot
                armed <= 1'b0;
                if (tx.line_bit)
                    tx.done <= 1'b1;
                else
                    tx.next_req <= 1'b1;
            end
        end
    end

endmodule

//--- hw/eeprom_top.sv
`timescale 1ns/100ps

module eeprom_top (
    input  logic scl,
    input  logic reset,
    input  logic bus_clk,
    input  logic bus_data_in,
    output logic bus_data_oe
);

    logic ack_low;
    logic tx_low;

    byte_link_if link_if ();
    tx_link_if   tx_if ();

    bus_decoder u_decoder (
        .scl         (scl),
        .reset       (reset),
        .bus_clk     (bus_clk),
        .bus_data_in (bus_data_in),
        .link        (link_if.decoder),
        .tx          (tx_if.decoder),
        .ack_low     (ack_low)
    );

    command_engine u_engine (
        .scl   (scl),
        .reset (reset),
        .link  (link_if.engine),
        .tx    (tx_if.engine)
    );

    read_shifter u_shifter (
        .scl    (scl),
        .reset  (reset),
        .tx     (tx_if.shifter),
        .tx_low (tx_low)
    );

    // either source pulls the pad low
    assign bus_data_oe = ack_low | tx_low;

endmodule

//--- dv/eeprom_tb.sv
`timescale 1ns/100ps
`include "eeprom_config.svh"

module eeprom_tb;

    localparam int HALF     = 10;
    localparam int OP_WRITE = 0;
    localparam int OP_RREAD = 1;
    localparam int OP_CREAD = 2;
    localparam int OP_BAD   = 3;
    localparam int OP_ABORT = 4;

    logic scl;
    logic reset;
    logic bus_clk;
    logic bus_data_in;
    logic bus_data_oe;

    // transaction table, one entry per index
    int         op_q[$];
    logic [2:0] page_q[$];
    logic [7:0] addr_q[$];
    int         count_q[$];
    logic       ack_q[$];

    logic [7:0] ref_mem [0:`EEPROM_DEPTH-1];
    logic [`EEPROM_ADDR_W-1:0] cur_addr;
    int   checks;
    int   errors;
    logic timed_out;
    logic watch_oe;
    logic oe_seen;

    eeprom_top i_eeprom_top (
        .scl         (scl),
        .reset       (reset),
        .bus_clk     (bus_clk),
        .bus_data_in (bus_data_in),
        .bus_data_oe (bus_data_oe)
    );

    always #2 scl = ~scl;

    // every master step lands on a falling edge
    task automatic idle(input int n);
        repeat (n)
        begin
            @(negedge scl);
            if (watch_oe && bus_data_oe)
                oe_seen = 1'b1;
        end
    endtask

    // open drain, slave drive wins
    function automatic logic line_level();
        return bus_data_in & ~bus_data_oe;
    endfunction

    function automatic logic [7:0] control_byte(input logic [2:0] page, input logic rd);
        return {`EEPROM_DEV_TYPE, page, rd};
    endfunction

    function automatic string op_name(input int op);
        case (op)
            OP_WRITE: return "write";
            OP_RREAD: return "random read";
            OP_CREAD: return "current read";
            OP_BAD:   return "bad control";
            default:  return "abort";
        endcase
    endfunction

    task automatic bus_start();
        idle(HALF / 2);
        bus_data_in = 1'b1;
        idle(HALF / 2);
        bus_clk = 1'b1;
        idle(HALF / 2);
        bus_data_in = 1'b0;
        idle(HALF / 2);
        bus_clk = 1'b0;
    endtask

    task automatic bus_stop();
        idle(HALF / 2);
        bus_data_in = 1'b0;
        idle(HALF / 2);
        bus_clk = 1'b1;
        idle(HALF / 2);
        bus_data_in = 1'b1;
        idle(HALF / 2);
    endtask

    // data set mid low, line sampled mid high
    task automatic bus_bit(input logic drive, output logic seen);
        idle(HALF / 2);
        bus_data_in = drive;
        idle(HALF / 2);
        bus_clk = 1'b1;
        idle(HALF / 2);
        seen = line_level();
        idle(HALF / 2);
        bus_clk = 1'b0;
    endtask

    task automatic send_bits(input logic [7:0] value, input int nbits);
        logic seen;
        for (int i = 7; i > 7 - nbits; i--)
            bus_bit(value[i], seen);
    endtask

    task automatic send_byte(input logic [7:0] value, input logic exp_ack, input string what);
        logic seen;
        send_bits(value, 8);
        bus_bit(1'b1, seen);
        checks++;
        if (!seen !== exp_ack)
        begin
            errors++;
            $display("MISMATCH ack after %s byte %h: got %h expected %h",
                     what, value, !seen, exp_ack);
        end
    endtask

    // master answers the last byte with no-acknowledge
    task automatic read_seq(input logic [`EEPROM_ADDR_W-1:0] start, input int count);
        logic [`EEPROM_ADDR_W-1:0] a;
        logic [7:0] got;
        logic seen;
        a = start;
        for (int n = 0; n < count; n++)
        begin
            for (int i = 7; i >= 0; i--)
            begin
                bus_bit(1'b1, seen);
                got[i] = seen;
            end
            bus_bit(n == count - 1, seen);
            checks++;
            if (got !== ref_mem[a])
            begin
                errors++;
                $display("MISMATCH rd_data at %h: got %h expected %h", a, got, ref_mem[a]);
            end
            a = a + 1'b1;
        end
        cur_addr = a;
    endtask

    task automatic wait_release();
        int n;
        n = 0;
        while (bus_data_oe && n < 5 * HALF)
        begin
            idle(1);
            n++;
        end
        if (bus_data_oe)
        begin
            timed_out = 1'b1;
            errors++;
            $display("timeout: bus_data_oe still asserted %0d cycles after the stop", n);
        end
        idle(2 * HALF);
    endtask

    task automatic add_txn(input int op, input int page, input int low, input int count,
                           input logic ack);
        op_q.push_back(op);
        page_q.push_back(page[2:0]);
        addr_q.push_back(low[7:0]);
        count_q.push_back(count);
        ack_q.push_back(ack);
    endtask

    task automatic build_table();
        add_txn(OP_WRITE, 1, 8'h20, 1, 1'b1);
        add_txn(OP_RREAD, 1, 8'h20, 1, 1'b1);
        // 2046 up through the wrap to 1
        add_txn(OP_WRITE, 7, 8'hfe, 4, 1'b1);
        add_txn(OP_RREAD, 7, 8'hfe, 4, 1'b1);
        add_txn(OP_WRITE, 2, 8'h10, 4, 1'b1);
        add_txn(OP_WRITE, 2, 8'h10, 2, 1'b1);
        add_txn(OP_CREAD, 2, 8'h00, 2, 1'b1);
        add_txn(OP_BAD,   1, 8'h00, 0, 1'b0);
        add_txn(OP_RREAD, 1, 8'h20, 1, 1'b1);
        add_txn(OP_WRITE, 3, 8'h40, 1, 1'b1);
        add_txn(OP_WRITE, 5, 8'h40, 1, 1'b1);
        add_txn(OP_RREAD, 3, 8'h40, 1, 1'b1);
        add_txn(OP_RREAD, 5, 8'h40, 1, 1'b1);
        add_txn(OP_ABORT, 5, 8'h40, 0, 1'b1);
        add_txn(OP_RREAD, 5, 8'h40, 1, 1'b1);
    endtask

    task automatic run_txn(input int idx);
        int op;
        logic [2:0] page;
        logic [7:0] low;
        int count;
        logic exp_ack;
        logic [`EEPROM_ADDR_W-1:0] a;
        logic [7:0] data;
        int errs_before;
        op = op_q[idx];
        page = page_q[idx];
        low = addr_q[idx];
        count = count_q[idx];
        exp_ack = ack_q[idx];
        errs_before = errors;
        a = {page, low};
        bus_start();
        case (op)
            OP_WRITE:
            begin
                send_byte(control_byte(page, 1'b0), exp_ack, "control");
                send_byte(low, exp_ack, "address");
                for (int n = 0; n < count; n++)
                begin
                    data = 8'($urandom());
                    send_byte(data, exp_ack, "data");
                    ref_mem[a] = data;
                    a = a + 1'b1;
                end
                cur_addr = a;
            end
            OP_RREAD:
            begin
                send_byte(control_byte(page, 1'b0), exp_ack, "control");
                send_byte(low, exp_ack, "address");
                bus_start();
                send_byte(control_byte(page, 1'b1), exp_ack, "read control");
                read_seq(a, count);
            end
            OP_CREAD:
            begin
                // page bits replace the upper address bits
                a = {page, cur_addr[7:0]};
                send_byte(control_byte(page, 1'b1), exp_ack, "read control");
                read_seq(a, count);
            end
            OP_BAD:
            begin
                oe_seen = 1'b0;
                watch_oe = 1'b1;
                send_byte({4'b1011, page, 1'b0}, exp_ack, "bad control");
            end
            default:
            begin
                send_byte(control_byte(page, 1'b0), exp_ack, "control");
                send_byte(low, exp_ack, "address");
                send_bits(8'($urandom()), 4);
                cur_addr = a;
            end
        endcase
        bus_stop();
        if (op == OP_BAD)
        begin
            watch_oe = 1'b0;
            checks++;
            if (oe_seen)
            begin
                errors++;
                $display("bus_data_oe was driven during a transaction with a refused control byte");
            end
        end
        wait_release();
        $display("txn %0d %s page %0d addr %h: %s", idx, op_name(op), page, low,
                 (errors == errs_before) ? "ok" : "FAILED");
    endtask

    initial
    begin
        void'($urandom(32'h04641e49));
        scl = 1'b0;
        reset = 1'b1;
        bus_clk = 1'b1;
        bus_data_in = 1'b1;
        checks = 0;
        errors = 0;
        timed_out = 1'b0;
        watch_oe = 1'b0;
        oe_seen = 1'b0;
        cur_addr = '0;
        build_table();
        repeat (8) @(negedge scl);
        reset = 1'b0;
        idle(2 * HALF);
        for (int i = 0; i < op_q.size(); i++)
        begin
            run_txn(i);
            if (timed_out)
                break;
        end
        $display("%0d transactions, %0d checks, %0d errors", op_q.size(), checks, errors);
        if (errors == 0 && !timed_out)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- build.f
+incdir+include
hw/eeprom_pkg.sv
hw/eeprom_links.sv
hw/bus_decoder.sv
hw/command_engine.sv
hw/read_shifter.sv
hw/eeprom_top.sv
dv/eeprom_tb.sv

//--- Makefile
# Verilator build and run for the serial EEPROM testbench

VERILATOR ?= verilator
TOP       ?= eeprom_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Test completed successfully
FAIL_MSG  ?= Test failed

SOURCES := $(wildcard hw/*.sv dv/*.sv include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no pass line found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
